// ==== source/htu_geom_pkg.sv ====
package htu_geom_pkg;

  //----------------------------------------
  // bank geometry
  //----------------------------------------
  localparam int ADDR_HI  = 31;
  localparam int SET_BITS = 3;
  localparam int WAY_BITS = 3;
  // tag starts right above the set index
  localparam int TAG_LO   = 8;

  //----------------------------------------
  // address fields
  //----------------------------------------
  typedef logic [SET_BITS-1:0] set_t;
  typedef logic [WAY_BITS-1:0] way_t;

  typedef logic [ADDR_HI:TAG_LO] tag_t;

  // {set, way} as seen by issue and bus units
  typedef logic [SET_BITS+WAY_BITS-1:0] set_way_t;

  // 32-byte line address
  typedef logic [ADDR_HI:5] line_addr_t;

endpackage

// ==== source/htu_op_pkg.sv ====
package htu_op_pkg;

  //----------------------------------------
  // crossbar request opcode
  //----------------------------------------
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01
  } op_e;

  // state of one half line
  typedef enum logic [1:0] {
    ST_EMPTY = 2'b00,
    ST_CLEAN = 2'b01,
    ST_DIRTY = 2'b11
  } half_state_e;

  // issue opcode bit positions
  localparam int ISU_OP_WRITE = 0;
  localparam int ISU_OP_EVICT = 1;

endpackage

// ==== source/htu_probe_if.sv ====
`timescale 1ns/1ps

interface htu_probe_if #(
  parameter int WAY_BITS = htu_geom_pkg::WAY_BITS
);

  localparam int NUM_WAYS = 2**WAY_BITS;

  htu_geom_pkg::set_t               set;
  htu_geom_pkg::tag_t               tags  [NUM_WAYS];
  logic [NUM_WAYS-1:0]              valid;
  htu_op_pkg::half_state_e          half0 [NUM_WAYS];
  htu_op_pkg::half_state_e          half1 [NUM_WAYS];
  // either half dirty
  logic [NUM_WAYS-1:0]              dirty;
  htu_geom_pkg::way_t               victim;

  modport lookup (
    output set,
    input  tags, valid, half0, half1, dirty, victim
  );

  modport arrays (
    input  set,
    output tags, valid, half0, half1, dirty, victim
  );

endinterface

// ==== source/htu_update_if.sv ====
`timescale 1ns/1ps

interface htu_update_if;

  // new line allocated on a miss
  logic                   install;
  htu_geom_pkg::set_way_t install_set_way;
  htu_geom_pkg::tag_t     install_tag;

  // write to one half
  logic                   mark_dirty;
  htu_geom_pkg::set_way_t dirty_set_way;
  logic                   dirty_half;

  // refill finished by the issue unit
  logic                   fill_done;
  htu_geom_pkg::set_way_t fill_set_way;

  modport source (
    output install, install_set_way, install_tag,
    output mark_dirty, dirty_set_way, dirty_half
  );

  modport sink (
    input install, install_set_way, install_tag,
    input mark_dirty, dirty_set_way, dirty_half,
    input fill_done, fill_set_way
  );

endinterface

// ==== source/htu_lookup.sv ====
`timescale 1ns/1ps

module htu_lookup (
  input  logic                          xbar_valid_i,
  input  logic                          isu_allow_in_i,
  input  htu_op_pkg::op_e               opcode_i,
  input  logic [1:0]                    ch_id_i,
  input  logic [htu_geom_pkg::ADDR_HI:4] addr_i,
  htu_probe_if.lookup                   probe,
  htu_update_if.source                  upd,
  output logic                          isu_valid_o,
  output logic [1:0]                    isu_opcode_o,
  output logic [1:0]                    isu_ch_id_o,
  output logic [6:0]                    isu_set_way_offset_o,
  output htu_op_pkg::half_state_e       isu_half0_state_o,
  output htu_op_pkg::half_state_e       isu_half1_state_o,
  output logic                          linefill_o,
  output htu_geom_pkg::set_way_t        linefill_set_way_o
);

  localparam int NUM_WAYS = 2**htu_geom_pkg::WAY_BITS;

  htu_geom_pkg::tag_t      req_tag;
  htu_geom_pkg::set_t      req_set;
  logic                    req_half;
  logic                    op_is_read;
  logic                    op_is_write;
  logic                    hit;
  htu_geom_pkg::way_t      hit_way;
  htu_geom_pkg::way_t      access_way;
  htu_op_pkg::half_state_e access_state;
  logic                    evict;
  logic                    accept;

  //----------------------------------------
  // request decode
  //----------------------------------------
  assign req_tag  = addr_i[htu_geom_pkg::ADDR_HI:htu_geom_pkg::TAG_LO];
  assign req_set  = addr_i[htu_geom_pkg::TAG_LO-1:5];
  assign req_half = addr_i[4];

  assign op_is_read  = opcode_i == htu_op_pkg::OP_READ;
  assign op_is_write = opcode_i == htu_op_pkg::OP_WRITE;
  assign accept      = xbar_valid_i & isu_allow_in_i;

  assign probe.set = req_set;

  //----------------------------------------
  // tag compare and way choice
  //----------------------------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (probe.valid[w] && probe.tags[w] == req_tag) begin
        hit     = 1'b1;
        hit_way = htu_geom_pkg::WAY_BITS'(w);
      end
    end
  end

  // miss goes to the round-robin victim
  assign access_way   = hit ? hit_way : probe.victim;
  assign access_state = req_half ? probe.half1[access_way] : probe.half0[access_way];

  assign evict      = ~hit & probe.valid[access_way] & probe.dirty[access_way];
  assign linefill_o = xbar_valid_i & op_is_read
                    & (~hit | access_state == htu_op_pkg::ST_EMPTY);

  //----------------------------------------
  // issue unit outputs
  //----------------------------------------
  always_comb begin
    isu_opcode_o                           = '0;
    isu_opcode_o[htu_op_pkg::ISU_OP_WRITE] = op_is_write;
    isu_opcode_o[htu_op_pkg::ISU_OP_EVICT] = evict;
  end

  assign isu_valid_o          = xbar_valid_i;
  assign isu_ch_id_o          = ch_id_i;
  assign isu_set_way_offset_o = {req_set, access_way, req_half};
  assign isu_half0_state_o    = probe.half0[access_way];
  assign isu_half1_state_o    = probe.half1[access_way];
  assign linefill_set_way_o   = {req_set, access_way};

  // write-allocate, so a write miss installs too
  assign upd.install         = accept & ~hit;
  assign upd.install_set_way = {req_set, access_way};
  assign upd.install_tag     = req_tag;
  assign upd.mark_dirty      = accept & op_is_write;
  assign upd.dirty_set_way   = {req_set, access_way};
  assign upd.dirty_half      = req_half;

endmodule

// ==== source/htu_tag_array.sv ====
`timescale 1ns/1ps

module htu_tag_array #(
  parameter int SET_BITS = htu_geom_pkg::SET_BITS,
  parameter int WAY_BITS = htu_geom_pkg::WAY_BITS
) (
  input  logic         clk_i,
  input  logic         reset_i,
  htu_probe_if.arrays  probe,
  htu_update_if.sink   upd
);

  localparam int NUM_SETS = 2**SET_BITS;
  localparam int NUM_WAYS = 2**WAY_BITS;

  htu_geom_pkg::tag_t                tag_mem [NUM_SETS][NUM_WAYS];
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  logic [SET_BITS-1:0]               inst_set;
  logic [WAY_BITS-1:0]               inst_way;

  assign inst_set = upd.install_set_way[WAY_BITS +: SET_BITS];
  assign inst_way = upd.install_set_way[WAY_BITS-1:0];

  // read port for the addressed set
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      probe.tags[w] = tag_mem[probe.set][w];
    end
  end

  assign probe.valid = valid_q[probe.set];

  always_ff @(posedge clk_i) begin
    if (upd.install) begin
      tag_mem[inst_set][inst_way] <= upd.install_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (upd.install) begin
      valid_q[inst_set][inst_way] <= 1'b1;
    end
  end

endmodule

// ==== source/htu_line_state.sv ====
`timescale 1ns/1ps

module htu_line_state #(
  parameter int SET_BITS = htu_geom_pkg::SET_BITS,
  parameter int WAY_BITS = htu_geom_pkg::WAY_BITS
) (
  input  logic         clk_i,
  input  logic         reset_i,
  htu_probe_if.arrays  probe,
  htu_update_if.sink   upd
);

  localparam int NUM_SETS = 2**SET_BITS;
  localparam int NUM_WAYS = 2**WAY_BITS;

  htu_op_pkg::half_state_e st_q [NUM_SETS][NUM_WAYS][2];

  // later checks take priority, request beats refill
  function automatic htu_op_pkg::half_state_e half_next(
    htu_op_pkg::half_state_e cur,
    logic                    fill,
    logic                    inst,
    logic                    dirty
  );
    htu_op_pkg::half_state_e nxt;
    nxt = cur;
    if (fill && cur == htu_op_pkg::ST_EMPTY) nxt = htu_op_pkg::ST_CLEAN;
    if (inst) nxt = htu_op_pkg::ST_EMPTY;
    if (dirty) nxt = htu_op_pkg::ST_DIRTY;
    return nxt;
  endfunction

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int h = 0; h < 2; h++) begin
          if (reset_i) begin
            st_q[s][w][h] <= htu_op_pkg::ST_EMPTY;
          end else begin
            st_q[s][w][h] <= half_next(
              st_q[s][w][h],
              upd.fill_done && upd.fill_set_way == {SET_BITS'(s), WAY_BITS'(w)},
              upd.install && upd.install_set_way == {SET_BITS'(s), WAY_BITS'(w)},
              upd.mark_dirty && upd.dirty_set_way == {SET_BITS'(s), WAY_BITS'(w)}
                && upd.dirty_half == 1'(h));
          end
        end
      end
    end
  end

  // states of the addressed set
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      probe.half0[w] = st_q[probe.set][w][0];
      probe.half1[w] = st_q[probe.set][w][1];
      probe.dirty[w] = st_q[probe.set][w][0] == htu_op_pkg::ST_DIRTY
                    || st_q[probe.set][w][1] == htu_op_pkg::ST_DIRTY;
    end
  end

endmodule

// ==== source/htu_victim_ptr.sv ====
`timescale 1ns/1ps

module htu_victim_ptr #(
  parameter int SET_BITS = htu_geom_pkg::SET_BITS,
  parameter int WAY_BITS = htu_geom_pkg::WAY_BITS
) (
  input  logic         clk_i,
  input  logic         reset_i,
  htu_probe_if.arrays  probe,
  htu_update_if.sink   upd
);

  localparam int NUM_SETS = 2**SET_BITS;

  logic [NUM_SETS-1:0][WAY_BITS-1:0] ptr_q;
  logic [SET_BITS-1:0]               inst_set;

  assign inst_set     = upd.install_set_way[WAY_BITS +: SET_BITS];
  assign probe.victim = ptr_q[probe.set];

  // wraps after the last way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (upd.install) begin
      ptr_q[inst_set] <= ptr_q[inst_set] + WAY_BITS'(1);
    end
  end

endmodule

// ==== source/bank_htu.sv ====
`timescale 1ns/1ps

module bank_htu #(
  parameter int SET_BITS = htu_geom_pkg::SET_BITS,
  parameter int WAY_BITS = htu_geom_pkg::WAY_BITS
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // crossbar request
  input  logic                           xbar_valid_i,
  output logic                           xbar_allow_in_o,
  input  logic [1:0]                     xbar_ch_id_i,
  input  htu_op_pkg::op_e                xbar_opcode_i,
  input  logic [htu_geom_pkg::ADDR_HI:4] xbar_addr_i,
  // issue unit
  output logic                           isu_valid_o,
  input  logic                           isu_allow_in_i,
  output logic [1:0]                     isu_ch_id_o,
  output logic [1:0]                     isu_opcode_o,
  output logic [6:0]                     isu_set_way_offset_o,
  output htu_op_pkg::half_state_e        isu_half0_state_o,
  output htu_op_pkg::half_state_e        isu_half1_state_o,
  output logic                           isu_linefill_valid_o,
  output htu_geom_pkg::set_t             isu_linefill_set_o,
  output htu_geom_pkg::way_t             isu_linefill_way_o,
  input  logic                           isu_fill_done_i,
  input  htu_geom_pkg::set_way_t         isu_fill_set_way_i,
  // bus interface refill request
  output logic                           biu_valid_o,
  output htu_geom_pkg::set_way_t         biu_set_way_o,
  output htu_geom_pkg::line_addr_t       biu_addr_o
);

  logic                   linefill;
  htu_geom_pkg::set_way_t linefill_set_way;

  htu_probe_if #(.WAY_BITS(WAY_BITS)) probe ();
  htu_update_if upd ();

  assign upd.fill_done    = isu_fill_done_i;
  assign upd.fill_set_way = isu_fill_set_way_i;

  //----------------------------------------
  // outputs
  //----------------------------------------
  assign xbar_allow_in_o      = isu_allow_in_i;
  assign isu_linefill_valid_o = linefill;
  assign isu_linefill_set_o   = linefill_set_way[WAY_BITS +: SET_BITS];
  assign isu_linefill_way_o   = linefill_set_way[WAY_BITS-1:0];
  assign biu_valid_o          = linefill;
  assign biu_set_way_o        = linefill_set_way;
  assign biu_addr_o           = xbar_addr_i[htu_geom_pkg::ADDR_HI:5];

  htu_lookup u_lookup (
    .xbar_valid_i        (xbar_valid_i),
    .isu_allow_in_i      (isu_allow_in_i),
    .opcode_i            (xbar_opcode_i),
    .ch_id_i             (xbar_ch_id_i),
    .addr_i              (xbar_addr_i),
    .probe               (probe.lookup),
    .upd                 (upd.source),
    .isu_valid_o         (isu_valid_o),
    .isu_opcode_o        (isu_opcode_o),
    .isu_ch_id_o         (isu_ch_id_o),
    .isu_set_way_offset_o(isu_set_way_offset_o),
    .isu_half0_state_o   (isu_half0_state_o),
    .isu_half1_state_o   (isu_half1_state_o),
    .linefill_o          (linefill),
    .linefill_set_way_o  (linefill_set_way)
  );

  //----------------------------------------
  // storage
  //----------------------------------------
  htu_tag_array #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) u_tag_array (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .probe  (probe.arrays),
    .upd    (upd.sink)
  );

  htu_line_state #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) u_line_state (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .probe  (probe.arrays),
    .upd    (upd.sink)
  );

  htu_victim_ptr #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) u_victim_ptr (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .probe  (probe.arrays),
    .upd    (upd.sink)
  );

endmodule

// ==== bench/tb_bank_htu.sv ====
`timescale 1ns/1ps

module tb_bank_htu;

  localparam int PERIOD     = 40;
  localparam int HOLD_LIMIT = 32;

  logic                    clk_i;
  logic                    reset_i;
  logic                    xbar_valid_i;
  logic                    xbar_allow_in_o;
  logic [1:0]              xbar_ch_id_i;
  htu_op_pkg::op_e         xbar_opcode_i;
  logic [31:4]             xbar_addr_i;
  logic                    isu_valid_o;
  logic                    isu_allow_in_i;
  logic [1:0]              isu_ch_id_o;
  logic [1:0]              isu_opcode_o;
  logic [6:0]              isu_set_way_offset_o;
  htu_op_pkg::half_state_e isu_half0_state_o;
  htu_op_pkg::half_state_e isu_half1_state_o;
  logic                    isu_linefill_valid_o;
  logic [2:0]              isu_linefill_set_o;
  logic [2:0]              isu_linefill_way_o;
  logic                    isu_fill_done_i;
  logic [5:0]              isu_fill_set_way_i;
  logic                    biu_valid_o;
  logic [5:0]              biu_set_way_o;
  logic [31:5]             biu_addr_o;

  // reference model of the bank
  logic [23:0] m_tag    [8][8];
  logic        m_valid  [8][8];
  logic [1:0]  m_state  [8][8][2];
  logic [2:0]  m_victim [8];
  logic [23:0] pool     [4];

  logic [23:0] e_tag;
  logic [2:0]  e_set;
  logic        e_half;
  logic        e_hit;
  logic [2:0]  e_way;
  logic        e_wr;
  logic        e_fill;
  logic        e_evict;

  logic [15:0] lfsr = 16'd55;
  int          value_errs = 0;
  int          timeout_errs = 0;

  bank_htu dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD/2) clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  //----------------------------------------
  // model lookup and update
  //----------------------------------------
  task automatic predict();
    e_tag  = xbar_addr_i[31:8];
    e_set  = xbar_addr_i[7:5];
    e_half = xbar_addr_i[4];
    e_wr   = xbar_opcode_i == htu_op_pkg::OP_WRITE;
    e_hit  = 1'b0;
    e_way  = m_victim[e_set];
    for (int w = 0; w < 8; w++) begin
      if (m_valid[e_set][w] && m_tag[e_set][w] == e_tag) begin
        e_hit = 1'b1;
        e_way = 3'(w);
      end
    end
    e_fill  = xbar_valid_i && !e_wr
            && (!e_hit || m_state[e_set][e_way][e_half] == htu_op_pkg::ST_EMPTY);
    e_evict = !e_hit && m_valid[e_set][e_way]
            && (m_state[e_set][e_way][0] == htu_op_pkg::ST_DIRTY
             || m_state[e_set][e_way][1] == htu_op_pkg::ST_DIRTY);
  endtask

  task automatic check_outputs();
    predict();
    assert (xbar_allow_in_o === isu_allow_in_i)
      else report_mismatch("xbar_allow_in_o", xbar_allow_in_o, isu_allow_in_i);
    assert (isu_valid_o === xbar_valid_i)
      else report_mismatch("isu_valid_o", isu_valid_o, xbar_valid_i);
    assert (isu_linefill_valid_o === e_fill)
      else report_mismatch("isu_linefill_valid_o", isu_linefill_valid_o, e_fill);
    assert (biu_valid_o === e_fill)
      else report_mismatch("biu_valid_o", biu_valid_o, e_fill);
    if (xbar_valid_i) begin
      assert (isu_opcode_o === {e_evict, e_wr})
        else report_mismatch("isu_opcode_o", isu_opcode_o, {e_evict, e_wr});
      assert (isu_ch_id_o === xbar_ch_id_i)
        else report_mismatch("isu_ch_id_o", isu_ch_id_o, xbar_ch_id_i);
      assert (isu_set_way_offset_o === {e_set, e_way, e_half})
        else report_mismatch("isu_set_way_offset_o", isu_set_way_offset_o,
                             {e_set, e_way, e_half});
      assert (isu_half0_state_o === m_state[e_set][e_way][0])
        else report_mismatch("isu_half0_state_o", isu_half0_state_o,
                             m_state[e_set][e_way][0]);
      assert (isu_half1_state_o === m_state[e_set][e_way][1])
        else report_mismatch("isu_half1_state_o", isu_half1_state_o,
                             m_state[e_set][e_way][1]);
      assert ({isu_linefill_set_o, isu_linefill_way_o} === {e_set, e_way})
        else report_mismatch("isu_linefill set/way",
                             {isu_linefill_set_o, isu_linefill_way_o}, {e_set, e_way});
      assert (biu_set_way_o === {e_set, e_way})
        else report_mismatch("biu_set_way_o", biu_set_way_o, {e_set, e_way});
      assert (biu_addr_o === {e_tag, e_set})
        else report_mismatch("biu_addr_o", biu_addr_o, {e_tag, e_set});
    end
  endtask

  // request wins over refill on the same half
  task automatic update_model();
    if (isu_fill_done_i) begin
      for (int h = 0; h < 2; h++) begin
        if (m_state[isu_fill_set_way_i[5:3]][isu_fill_set_way_i[2:0]][h]
            == htu_op_pkg::ST_EMPTY) begin
          m_state[isu_fill_set_way_i[5:3]][isu_fill_set_way_i[2:0]][h] =
            htu_op_pkg::ST_CLEAN;
        end
      end
    end
    if (xbar_valid_i && isu_allow_in_i) begin
      if (!e_hit) begin
        m_tag[e_set][e_way]      = e_tag;
        m_valid[e_set][e_way]    = 1'b1;
        m_state[e_set][e_way][0] = htu_op_pkg::ST_EMPTY;
        m_state[e_set][e_way][1] = htu_op_pkg::ST_EMPTY;
        m_victim[e_set]          = m_victim[e_set] + 3'd1;
      end
      if (e_wr) begin
        m_state[e_set][e_way][e_half] = htu_op_pkg::ST_DIRTY;
      end
    end
  endtask

  //----------------------------------------
  // stimulus
  //----------------------------------------
  task automatic drive_side();
    isu_allow_in_i     = rand_bits(2) != 0;
    isu_fill_done_i    = rand_bits(3) == 0;
    isu_fill_set_way_i = 6'(rand_bits(6));
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    xbar_valid_i  = 1'b0;
    xbar_addr_i   = 28'(rand_bits(28));
    xbar_opcode_i = rand_bits(1) ? htu_op_pkg::OP_WRITE : htu_op_pkg::OP_READ;
    drive_side();
    #(PERIOD/2 - 1);
    check_outputs();
    update_model();
  endtask

  // holds the request until the issue unit lets it in
  task automatic send_request(input logic [23:0] tag, input logic [2:0] set,
                              input logic half, input logic wr, input logic [1:0] ch);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < HOLD_LIMIT) begin
      @(negedge clk_i);
      xbar_valid_i  = 1'b1;
      xbar_addr_i   = {tag, set, half};
      xbar_opcode_i = wr ? htu_op_pkg::OP_WRITE : htu_op_pkg::OP_READ;
      xbar_ch_id_i  = ch;
      drive_side();
      #(PERIOD/2 - 1);
      check_outputs();
      accepted = isu_allow_in_i;
      update_model();
      waited++;
    end
    if (!accepted) begin
      timeout_errs++;
      $display("request to set %0d was not accepted within %0d cycles", set, HOLD_LIMIT);
    end
  endtask

  initial begin
    logic [1:0] sel;
    logic [2:0] set;
    logic       half;
    logic       wr;
    logic [1:0] ch;
    reset_i            = 1'b1;
    xbar_valid_i       = 1'b0;
    xbar_ch_id_i       = '0;
    xbar_opcode_i      = htu_op_pkg::OP_READ;
    xbar_addr_i        = '0;
    isu_allow_in_i     = 1'b0;
    isu_fill_done_i    = 1'b0;
    isu_fill_set_way_i = '0;
    for (int s = 0; s < 8; s++) begin
      m_victim[s] = '0;
      for (int w = 0; w < 8; w++) begin
        m_tag[s][w]      = '0;
        m_valid[s][w]    = 1'b0;
        m_state[s][w][0] = htu_op_pkg::ST_EMPTY;
        m_state[s][w][1] = htu_op_pkg::ST_EMPTY;
      end
    end
    for (int k = 0; k < 4; k++) begin
      pool[k] = {16'(rand_bits(16)), 8'hf0 + 8'(k)};
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // cold misses in every set
    for (int s = 0; s < 8; s++) begin
      send_request(pool[0], 3'(s), 1'b0, 1'b0, 2'(s));
    end
    // fresh tags in set 0 walk the victim pointer past way 7
    for (int i = 0; i < 10; i++) begin
      send_request({16'(rand_bits(16)), 8'(i)}, 3'd0, i[0], i[0], 2'(i));
    end
    for (int n = 0; n < 400; n++) begin
      if (rand_bits(3) == 0) begin
        idle_cycle();
      end else begin
        sel  = 2'(rand_bits(2));
        set  = 3'(rand_bits(3));
        half = rand_bits(1) != 0;
        wr   = rand_bits(1) != 0;
        ch   = 2'(rand_bits(2));
        send_request(pool[sel], set, half, wr, ch);
      end
    end
    idle_cycle();

    $display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/htu_geom_pkg.sv
source/htu_op_pkg.sv
source/htu_probe_if.sv
source/htu_update_if.sv
source/htu_lookup.sv
source/htu_tag_array.sv
source/htu_line_state.sv
source/htu_victim_ptr.sv
source/bank_htu.sv
bench/tb_bank_htu.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bank_htu -f files.f -o sim_tb_bank_htu

./obj_dir/sim_tb_bank_htu > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
